// ==== src.f ====
src/analog_pkg.sv
src/fast_codec.sv
src/pwm_timebase.sv
src/pwm_dac_channel.sv
src/monitor_capture.sv
src/analog_top.sv
testbench/tb_analog_sva.sv
testbench/tb_analog.sv

// ==== Bender.yml ====
package:
  name: analog_frontend

sources:
  - src/analog_pkg.sv
  - src/fast_codec.sv
  - src/pwm_timebase.sv
  - src/pwm_dac_channel.sv
  - src/monitor_capture.sv
  - src/analog_top.sv
  - target: simulation
    files:
      - testbench/tb_analog_sva.sv
      - testbench/tb_analog.sv

// ==== testbench/tb_analog.sv ====
//----------------------------------------------------------------------
// Analog front end testbench
// Random fast samples, PWM dither blocks and monitor transfers vs model
//----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_analog import analog_pkg::*; ();

  localparam int CLK_PERIOD   = 8;                        // ns
  localparam int SEED         = 86248;
  localparam int PWM_ROUNDS   = 4;                        // Word sets per channel
  localparam int MON_XFERS    = 40;                       // Monitor transfers
  localparam int SYNC_GAP     = PWM_BLOCK * int'(PWM_FULL);  // 2496 cycles
  localparam int WATCHDOG_CYC = (PWM_ROUNDS * 3 + 2) * SYNC_GAP + MON_XFERS * 20 + 200;

  logic              adc_clk = 1'b0;
  logic              dac_rst;
  adc_sample_t       adc_dat_a_i, adc_dat_b_i, adc_dat_a_o, adc_dat_b_o;
  adc_sample_t       dac_dat_a_i, dac_dat_b_i;
  dac_code_t         dac_dat_o;
  logic              dac_sel_o, dac_wrt_o, dac_rst_o;
  pwm_word_u         dac_pwm_a_i, dac_pwm_b_i, dac_pwm_c_i, dac_pwm_d_i;
  logic [PWM_CH-1:0] dac_pwm_o;
  logic              dac_pwm_sync_o;
  logic              drp_req_i, drp_ack_o;
  mon_addr_t         drp_addr_i;
  logic [DRP_W-1:0]  drp_data_i;
  mon_code_t         adc_slx_a_o, adc_slx_b_o, adc_slx_c_o, adc_slx_d_o;
  mon_code_t         adc_v_o, adc_temp_o, adc_pint_o, adc_paux_o;
  mon_code_t         adc_bram_o, adc_int_o, adc_aux_o, adc_ddr_o;

  logic [31:0] main_st = SEED;                           // Handshake and PWM stream
  logic [31:0] fast_st = ~SEED;                          // Fast sample stream
  logic [13:0] fast_w [4];
  adc_sample_t prev_adc_a, prev_adc_b, prev_dac_a, prev_dac_b, prev2_dac_b;
  logic        prev_rst  = 1'b1;
  logic        have_prev = 1'b0;
  mon_code_t   mon_model [32];                           // Expected result per address
  int          high_cnt [PWM_CH];                        // Open window
  int          win_high [PWM_CH];                        // Last closed window
  int          cyc, last_sync, n_sync;
  int          err_adc, err_dac, err_pwm, err_sync, err_mon;

  analog_top u_dut (.*);

  always #(CLK_PERIOD / 2) adc_clk = ~adc_clk;

  //--------------------------------------------------------------------
  // Model functions
  //--------------------------------------------------------------------

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;            // Full period mod 2^32
  endfunction

  function automatic logic [15:0] rand16();
    main_st = lcg(main_st);
    return main_st[31:16];
  endfunction

  function automatic logic [13:0] flip_low(input logic [13:0] x);
    return {x[13], ~x[12:0]};                            // Sign kept, rest flipped
  endfunction

  // High cycles in one dithered block
  function automatic int pwm_high(input logic [23:0] word);
    logic [7:0] eff;
    int         sum;
    sum = 0;
    for (int k = 0; k < 16; k++) begin
      eff = word[23:16] + {7'd0, word[k]};               // 8-bit wrap on 255
      sum += (eff >= 8'd156) ? 156 : int'(eff);
    end
    return sum;
  endfunction

  function automatic logic is_mapped(input mon_addr_t a);
    case (a)
      MON_TEMP, MON_INT, MON_AUX, MON_VIN, MON_BRAM, MON_PINT,
      MON_PAUX, MON_DDR, MON_SLX_A, MON_SLX_B, MON_SLX_C, MON_SLX_D: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  //--------------------------------------------------------------------
  // Compare tasks
  //--------------------------------------------------------------------

  task automatic check_sample(input string what, input adc_sample_t got, input adc_sample_t exp);
    if (got !== exp) begin
      err_adc++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_dac(input string what, input dac_code_t got, input dac_code_t exp);
    if (got !== exp) begin
      err_dac++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_pwm(input int ch, input int got, input int exp);
    if (got != exp) begin
      err_pwm++;
      $display("ERR %0t: pwm channel %0d high %0d expected %0d", $time, ch, got, exp);
    end
  endtask

  task automatic check_mon(input string what, input mon_code_t got, input mon_code_t exp);
    if (got !== exp) begin
      err_mon++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_sync(input int gap);
    if (gap != SYNC_GAP) begin
      err_sync++;
      $display("ERR %0t: sync spacing %0d expected %0d", $time, gap, SYNC_GAP);
    end
  endtask

  task automatic compare_monitor();
    check_mon("adc_temp_o", adc_temp_o, mon_model[MON_TEMP]);
    check_mon("adc_int_o", adc_int_o, mon_model[MON_INT]);
    check_mon("adc_aux_o", adc_aux_o, mon_model[MON_AUX]);
    check_mon("adc_v_o", adc_v_o, mon_model[MON_VIN]);
    check_mon("adc_bram_o", adc_bram_o, mon_model[MON_BRAM]);
    check_mon("adc_pint_o", adc_pint_o, mon_model[MON_PINT]);
    check_mon("adc_paux_o", adc_paux_o, mon_model[MON_PAUX]);
    check_mon("adc_ddr_o", adc_ddr_o, mon_model[MON_DDR]);
    check_mon("adc_slx_a_o", adc_slx_a_o, mon_model[MON_SLX_A]);
    check_mon("adc_slx_b_o", adc_slx_b_o, mon_model[MON_SLX_B]);
    check_mon("adc_slx_c_o", adc_slx_c_o, mon_model[MON_SLX_C]);
    check_mon("adc_slx_d_o", adc_slx_d_o, mon_model[MON_SLX_D]);
  endtask

  // One four-phase transfer, results checked once ack is seen
  task automatic mon_transfer(input mon_addr_t addr, input logic [15:0] data, input int gap);
    repeat (gap) @(posedge adc_clk);
    @(posedge adc_clk);
    drp_req_i  <= 1'b1;
    drp_addr_i <= addr;
    drp_data_i <= data;
    do @(negedge adc_clk); while (drp_ack_o !== 1'b1);
    if (is_mapped(addr)) begin
      mon_model[addr] = data[15:4];                      // Fraction nibble dropped
    end
    compare_monitor();
    @(posedge adc_clk);
    drp_req_i <= 1'b0;
    do @(negedge adc_clk); while (drp_ack_o !== 1'b0);
  endtask

  //--------------------------------------------------------------------
  // Fast stimulus and monitors
  //--------------------------------------------------------------------

  always @(posedge adc_clk) begin
    for (int i = 0; i < 4; i++) begin
      fast_st   = lcg(fast_st);
      fast_w[i] = fast_st[30:17];                        // Upper bits, longer period
    end
    adc_dat_a_i <= fast_w[0];
    adc_dat_b_i <= fast_w[1];
    dac_dat_a_i <= fast_w[2];
    dac_dat_b_i <= fast_w[3];
  end

  always @(negedge adc_clk) begin
    if (have_prev) begin
      check_sample("adc_dat_a_o", adc_dat_a_o, flip_low(prev_adc_a));
      check_sample("adc_dat_b_o", adc_dat_b_o, flip_low(prev_adc_b));
    end
    if (dac_rst_o !== prev_rst) begin
      err_dac++;
      $display("ERR %0t: dac_rst_o does not follow dac_rst", $time);
    end
    if (dac_wrt_o !== !prev_rst) begin
      err_dac++;
      $display("ERR %0t: dac_wrt_o %b after dac_rst %b", $time, dac_wrt_o, prev_rst);
    end
    if (prev_rst && (dac_sel_o !== 1'b0 || dac_dat_o !== '0)) begin
      err_dac++;
      $display("ERR %0t: dac bus not idle during reset", $time);
    end
    if (dac_wrt_o === 1'b1) begin
      if (dac_sel_o) begin
        check_dac("dac slot A", dac_dat_o, flip_low(prev_dac_a));
      end else begin
        check_dac("dac slot B", dac_dat_o, flip_low(prev2_dac_b));  // Held one slot
      end
    end
    if (!dac_rst) begin
      cyc++;
      for (int c = 0; c < PWM_CH; c++) begin
        if (dac_pwm_sync_o) begin
          win_high[c] = high_cnt[c];                     // Close the window
          high_cnt[c] = 0;
        end
        high_cnt[c] += int'(dac_pwm_o[c]);
      end
      if (dac_pwm_sync_o) begin
        if (n_sync > 0) begin
          check_sync(cyc - last_sync);                   // Also catches a long pulse
        end
        last_sync = cyc;
        n_sync++;
      end
    end
    prev_adc_a  = adc_dat_a_i;
    prev_adc_b  = adc_dat_b_i;
    prev2_dac_b = prev_dac_b;
    prev_dac_b  = dac_dat_b_i;
    prev_dac_a  = dac_dat_a_i;
    prev_rst    = dac_rst;
    have_prev   = 1'b1;
  end

  //--------------------------------------------------------------------
  // Test sequence
  //--------------------------------------------------------------------

  initial begin
    pwm_word_u   w [PWM_CH];
    logic [15:0] rnd;
    logic [15:0] data;
    int          n0;
    dac_rst     = 1'b1;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    dac_dat_a_i = '0;
    dac_dat_b_i = '0;
    dac_pwm_a_i = '0;
    dac_pwm_b_i = '0;
    dac_pwm_c_i = '0;
    dac_pwm_d_i = '0;
    drp_req_i   = 1'b0;
    drp_addr_i  = '0;
    drp_data_i  = '0;
    for (int a = 0; a < 32; a++) begin
      mon_model[a] = '0;
    end
    repeat (8) @(posedge adc_clk);
    dac_rst <= 1'b0;
    @(negedge adc_clk);
    compare_monitor();                                   // Cleared by reset

    for (int i = 0; i < MON_XFERS; i++) begin
      rnd  = rand16();
      data = rand16();
      mon_transfer(rnd[4:0], data, int'(rnd[9:8]));      // Address and idle gap
    end

    for (int r = 0; r < PWM_ROUNDS; r++) begin
      for (int c = 0; c < PWM_CH; c++) begin
        w[c].raw[15:0]  = rand16();                      // Dither
        rnd             = rand16();
        w[c].raw[23:16] = rnd[15:8];                     // Duty
      end
      if (r == 0) begin
        w[0].raw[23:16] = 8'hff;                         // Wraps to 0 on a dither bit
      end
      @(posedge adc_clk);
      dac_pwm_a_i <= w[0];
      dac_pwm_b_i <= w[1];
      dac_pwm_c_i <= w[2];
      dac_pwm_d_i <= w[3];
      n0 = n_sync;
      wait (n_sync == n0 + 3);                           // Third window sees new words only
      for (int c = 0; c < PWM_CH; c++) begin
        check_pwm(c, win_high[c], pwm_high(w[c].raw));
      end
    end

    repeat (4) @(posedge adc_clk);
    $display("Error counts: adc %0d, dac %0d, pwm %0d, sync %0d, mon %0d, sva %0d",
             err_adc, err_dac, err_pwm, err_sync, err_mon, u_dut.u_sva.fail_cnt);
    if (err_adc + err_dac + err_pwm + err_sync + err_mon + u_dut.u_sva.fail_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYC);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== testbench/tb_analog_sva.sv ====
//----------------------------------------------------------------------
// Protocol assertions for the monitor handshake and the DAC bus
//----------------------------------------------------------------------

`timescale 1ns/1ps

module analog_sva (
  input logic adc_clk,              // Converter clock
  input logic dac_rst,              // Synchronous reset, active high
  input logic req_i,                // Monitor request
  input logic ack_i,                // Monitor acknowledge
  input logic sel_i,                // DAC channel select
  input logic wrt_i                 // DAC write strobe
);

  int fail_cnt = 0;                 // Assertion failures so far

  // Ack only answers a pending request
  ack_rise: assert property (@(posedge adc_clk) disable iff (dac_rst)
    $rose(ack_i) |-> $past(req_i))
    else begin
      $error("drp_ack_o rose while drp_req_i was low");
      fail_cnt++;
    end

  // Release waits for the source to drop req
  ack_fall: assert property (@(posedge adc_clk) disable iff (dac_rst)
    $fell(ack_i) |-> !$past(req_i))
    else begin
      $error("drp_ack_o fell while drp_req_i was still high");
      fail_cnt++;
    end

  sel_toggle: assert property (@(posedge adc_clk) disable iff (dac_rst)
    (wrt_i && $past(wrt_i)) |-> (sel_i != $past(sel_i)))  // A and B slots interleave
    else begin
      $error("dac_sel_o did not alternate while writing");
      fail_cnt++;
    end

  wrt_in_reset: assert property (@(posedge adc_clk)
    $past(dac_rst) |-> !wrt_i)                            // No writes out of reset state
    else begin
      $error("dac_wrt_o high during reset");
      fail_cnt++;
    end

endmodule

bind analog_top analog_sva u_sva (
  .adc_clk (adc_clk),
  .dac_rst (dac_rst),
  .req_i   (drp_req_i),
  .ack_i   (drp_ack_o),
  .sel_i   (dac_sel_o),
  .wrt_i   (dac_wrt_o)
);

// ==== src/analog_top.sv ====
//----------------------------------------------------------------------
// Analog front end top level
// Fast codec, PWM slow DAC and monitor capture on one clock
//----------------------------------------------------------------------

`timescale 1ns/1ps

module analog_top import analog_pkg::*; (
  input  logic              adc_clk,         // Converter clock
  input  logic              dac_rst,         // Synchronous reset, active high

  // Fast ADC
  input  adc_sample_t       adc_dat_a_i,
  input  adc_sample_t       adc_dat_b_i,
  output adc_sample_t       adc_dat_a_o,
  output adc_sample_t       adc_dat_b_o,

  // Fast DAC
  input  adc_sample_t       dac_dat_a_i,
  input  adc_sample_t       dac_dat_b_i,
  output dac_code_t         dac_dat_o,
  output logic              dac_sel_o,
  output logic              dac_wrt_o,
  output logic              dac_rst_o,

  // PWM slow DAC
  input  pwm_word_u         dac_pwm_a_i,
  input  pwm_word_u         dac_pwm_b_i,
  input  pwm_word_u         dac_pwm_c_i,
  input  pwm_word_u         dac_pwm_d_i,
  output logic [PWM_CH-1:0] dac_pwm_o,
  output logic              dac_pwm_sync_o,

  // Monitor readout
  input  logic              drp_req_i,
  input  mon_addr_t         drp_addr_i,
  input  logic [DRP_W-1:0]  drp_data_i,
  output logic              drp_ack_o,
  output mon_code_t         adc_slx_a_o,
  output mon_code_t         adc_slx_b_o,
  output mon_code_t         adc_slx_c_o,
  output mon_code_t         adc_slx_d_o,
  output mon_code_t         adc_v_o,
  output mon_code_t         adc_temp_o,
  output mon_code_t         adc_pint_o,
  output mon_code_t         adc_paux_o,
  output mon_code_t         adc_bram_o,
  output mon_code_t         adc_int_o,
  output mon_code_t         adc_aux_o,
  output mon_code_t         adc_ddr_o
);

  pwm_cnt_t  pwm_cnt;                        // Shared period count
  logic      pwm_load;                       // Block boundary
  logic      pwm_shift;                      // Period boundary
  pwm_word_u pwm_word [PWM_CH];              // Words in channel order

  assign pwm_word[0] = dac_pwm_a_i;
  assign pwm_word[1] = dac_pwm_b_i;
  assign pwm_word[2] = dac_pwm_c_i;
  assign pwm_word[3] = dac_pwm_d_i;

  fast_codec u_codec (
    .adc_clk     (adc_clk),
    .dac_rst     (dac_rst),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .adc_dat_a_o (adc_dat_a_o),
    .adc_dat_b_o (adc_dat_b_o),
    .dac_dat_a_i (dac_dat_a_i),
    .dac_dat_b_i (dac_dat_b_i),
    .dac_dat_o   (dac_dat_o),
    .dac_sel_o   (dac_sel_o),
    .dac_wrt_o   (dac_wrt_o),
    .dac_rst_o   (dac_rst_o)
  );

  //--------------------------------------------------------------------
  // PWM slow DAC
  //--------------------------------------------------------------------

  pwm_timebase u_timebase (
    .adc_clk        (adc_clk),
    .dac_rst        (dac_rst),
    .pwm_cnt_o      (pwm_cnt),
    .pwm_load_o     (pwm_load),
    .pwm_shift_o    (pwm_shift),
    .dac_pwm_sync_o (dac_pwm_sync_o)
  );

  for (genvar ch = 0; ch < PWM_CH; ch++) begin : g_pwm
    pwm_dac_channel u_pwm (
      .adc_clk     (adc_clk),
      .dac_rst     (dac_rst),
      .pwm_word_i  (pwm_word[ch]),
      .pwm_cnt_i   (pwm_cnt),
      .pwm_load_i  (pwm_load),
      .pwm_shift_i (pwm_shift),
      .pwm_o       (dac_pwm_o[ch])
    );
  end

  monitor_capture u_monitor (
    .adc_clk     (adc_clk),
    .dac_rst     (dac_rst),
    .drp_req_i   (drp_req_i),
    .drp_addr_i  (drp_addr_i),
    .drp_data_i  (drp_data_i),
    .drp_ack_o   (drp_ack_o),
    .adc_slx_a_o (adc_slx_a_o),
    .adc_slx_b_o (adc_slx_b_o),
    .adc_slx_c_o (adc_slx_c_o),
    .adc_slx_d_o (adc_slx_d_o),
    .adc_v_o     (adc_v_o),
    .adc_temp_o  (adc_temp_o),
    .adc_pint_o  (adc_pint_o),
    .adc_paux_o  (adc_paux_o),
    .adc_bram_o  (adc_bram_o),
    .adc_int_o   (adc_int_o),
    .adc_aux_o   (adc_aux_o),
    .adc_ddr_o   (adc_ddr_o)
  );

endmodule

// ==== src/monitor_capture.sv ====
//----------------------------------------------------------------------
// Monitor ADC capture
// Four-phase req/ack slave storing results by monitor channel address
//----------------------------------------------------------------------

`timescale 1ns/1ps

module monitor_capture import analog_pkg::*; (
  input  logic             adc_clk,      // Converter clock
  input  logic             dac_rst,      // Synchronous reset, active high

  input  logic             drp_req_i,    // Result offered
  input  mon_addr_t        drp_addr_i,   // Channel of the result
  input  logic [DRP_W-1:0] drp_data_i,   // Left-justified readout word
  output logic             drp_ack_o,    // Result taken

  output mon_code_t        adc_slx_a_o,  // Slow input A
  output mon_code_t        adc_slx_b_o,  // Slow input B
  output mon_code_t        adc_slx_c_o,  // Slow input C
  output mon_code_t        adc_slx_d_o,  // Slow input D
  output mon_code_t        adc_v_o,      // VP/VN input
  output mon_code_t        adc_temp_o,   // Temperature
  output mon_code_t        adc_pint_o,   // VCCPINT
  output mon_code_t        adc_paux_o,   // VCCPAUX
  output mon_code_t        adc_bram_o,   // VCCBRAM
  output mon_code_t        adc_int_o,    // VCCINT
  output mon_code_t        adc_aux_o,    // VCCAUX
  output mon_code_t        adc_ddr_o     // VCCO DDR
);

  logic      take;                       // New request, not yet acked
  mon_code_t code;                       // Upper bits of the readout

  assign take = drp_req_i && !drp_ack_o;
  assign code = drp_data_i[DRP_W-1 -: MON_W];  // Low nibble is fraction

  //--------------------------------------------------------------------
  // Handshake
  //--------------------------------------------------------------------

  always_ff @(posedge adc_clk) begin
    if (dac_rst) begin
      drp_ack_o <= 1'b0;
    end else if (take) begin
      drp_ack_o <= 1'b1;                 // Ack the cycle after the write
    end else if (drp_ack_o && !drp_req_i) begin
      drp_ack_o <= 1'b0;                 // Release once req is gone
    end
  end

  //--------------------------------------------------------------------
  // Result registers
  //--------------------------------------------------------------------

  always_ff @(posedge adc_clk) begin
    if (dac_rst) begin
      adc_slx_a_o <= '0;
      adc_slx_b_o <= '0;
      adc_slx_c_o <= '0;
      adc_slx_d_o <= '0;
      adc_v_o     <= '0;
      adc_temp_o  <= '0;
      adc_pint_o  <= '0;
      adc_paux_o  <= '0;
      adc_bram_o  <= '0;
      adc_int_o   <= '0;
      adc_aux_o   <= '0;
      adc_ddr_o   <= '0;
    end else if (take) begin
      case (drp_addr_i)
        MON_TEMP:  adc_temp_o  <= code;
        MON_INT:   adc_int_o   <= code;
        MON_AUX:   adc_aux_o   <= code;
        MON_VIN:   adc_v_o     <= code;
        MON_BRAM:  adc_bram_o  <= code;
        MON_PINT:  adc_pint_o  <= code;
        MON_PAUX:  adc_paux_o  <= code;
        MON_DDR:   adc_ddr_o   <= code;
        MON_SLX_B: adc_slx_b_o <= code;
        MON_SLX_C: adc_slx_c_o <= code;
        MON_SLX_A: adc_slx_a_o <= code;
        MON_SLX_D: adc_slx_d_o <= code;
        default: ;                       // Unmapped, acked and dropped
      endcase
    end
  end

endmodule

// ==== src/pwm_dac_channel.sv ====
//----------------------------------------------------------------------
// PWM DAC channel
// Dithered duty with a three-stage compare pipeline to the output pin
//----------------------------------------------------------------------

`timescale 1ns/1ps

module pwm_dac_channel import analog_pkg::*; (
  input  logic      adc_clk,        // Converter clock
  input  logic      dac_rst,        // Synchronous reset, active high

  input  pwm_word_u pwm_word_i,     // Duty and dither word
  input  pwm_cnt_t  pwm_cnt_i,      // Shared period count
  input  logic      pwm_load_i,     // Take a new word
  input  logic      pwm_shift_i,    // Next dither bit
  output logic      pwm_o           // Drives the RC filter
);

  pwm_cnt_t    duty_q;              // Base duty for the block
  logic [15:0] dither_q;            // Bit 0 adds one count this period
  pwm_cnt_t    duty_eff_q;          // Stage 1, duty plus dither bit
  pwm_cnt_t    cnt_q;               // Stage 1, count aligned with duty
  logic        cmp_q;               // Stage 2, compare result

  //--------------------------------------------------------------------
  // Word load and dither shift
  //--------------------------------------------------------------------

  always_ff @(posedge adc_clk) begin
    if (dac_rst) begin
      duty_q   <= '0;
      dither_q <= '0;
    end else if (pwm_load_i) begin
      duty_q   <= pwm_word_i.f.duty;          // Held for a whole block
      dither_q <= pwm_word_i.f.dither;
    end else if (pwm_shift_i) begin
      dither_q <= {1'b0, dither_q[15:1]};     // One bit per period
    end
  end

  //--------------------------------------------------------------------
  // Compare pipeline
  //--------------------------------------------------------------------

  always_ff @(posedge adc_clk) begin
    duty_eff_q <= duty_q + pwm_cnt_t'(dither_q[0]);  // 8-bit wrap on 255
    cnt_q      <= pwm_cnt_i;
  end

  always_ff @(posedge adc_clk) begin
    if (dac_rst) begin
      cmp_q <= 1'b0;
      pwm_o <= 1'b0;
    end else begin
      cmp_q <= (cnt_q <= duty_eff_q);         // High up to the duty count
      pwm_o <= cmp_q;                         // Clean pin register
    end
  end

endmodule

// ==== src/pwm_timebase.sv ====
//----------------------------------------------------------------------
// PWM timebase
// Period and dither block counters with load, shift and sync decode
//----------------------------------------------------------------------

`timescale 1ns/1ps

module pwm_timebase import analog_pkg::*; (
  input  logic     adc_clk,         // Converter clock
  input  logic     dac_rst,         // Synchronous reset, active high

  output pwm_cnt_t pwm_cnt_o,       // Period count to all channels
  output logic     pwm_load_o,      // Take new words, end of block
  output logic     pwm_shift_o,     // Shift dither, end of period
  output logic     dac_pwm_sync_o   // One cycle ahead of the load
);

  pwm_cnt_t   cnt_q;                // Period counter, 1 to PWM_FULL
  logic [3:0] bcnt_q;               // Period index inside the block
  logic       per_end;              // Last count of a period
  logic       blk_last;             // Last period of a block

  //--------------------------------------------------------------------
  // Counters
  //--------------------------------------------------------------------

  always_ff @(posedge adc_clk) begin
    if (dac_rst) begin
      cnt_q  <= '0;
      bcnt_q <= '0;
    end else begin
      cnt_q <= per_end ? 8'd1 : cnt_q + 8'd1;  // Zero only right after reset
      if (per_end) begin
        bcnt_q <= bcnt_q + 4'd1;              // Wraps once per block
      end
    end
  end

  //--------------------------------------------------------------------
  // Event decode
  //--------------------------------------------------------------------

  assign per_end  = (cnt_q == PWM_FULL);
  assign blk_last = (bcnt_q == 4'(PWM_BLOCK - 1));

  assign pwm_cnt_o      = cnt_q;
  assign pwm_shift_o    = per_end;
  assign pwm_load_o     = per_end && blk_last;              // Same edge as shift
  assign dac_pwm_sync_o = blk_last && (cnt_q == PWM_FULL - 8'd1);

endmodule

// ==== src/fast_codec.sv ====
//----------------------------------------------------------------------
// Fast converter codec
// ADC capture to two's complement, DAC conversion and channel multiplex
//----------------------------------------------------------------------

`timescale 1ns/1ps

module fast_codec import analog_pkg::*; (
  input  logic        adc_clk,      // Converter clock
  input  logic        dac_rst,      // Synchronous reset, active high

  input  adc_sample_t adc_dat_a_i,  // ADC channel A pins
  input  adc_sample_t adc_dat_b_i,  // ADC channel B pins
  output adc_sample_t adc_dat_a_o,  // Channel A, two's complement
  output adc_sample_t adc_dat_b_o,  // Channel B, two's complement

  input  adc_sample_t dac_dat_a_i,  // DAC channel A sample
  input  adc_sample_t dac_dat_b_i,  // DAC channel B sample
  output dac_code_t   dac_dat_o,    // Shared DAC data bus
  output logic        dac_sel_o,    // 1 selects channel A
  output logic        dac_wrt_o,    // DAC write strobe
  output logic        dac_rst_o     // DAC reset pin
);

  logic      phase_q;               // 0 while new samples are taken
  dac_code_t dac_b_q;               // Channel B held for the second slot

  //--------------------------------------------------------------------
  // ADC receive
  //--------------------------------------------------------------------

  always_ff @(posedge adc_clk) begin
    adc_dat_a_o <= adc_to_twos(adc_dat_a_i);  // Undo negative slope
    adc_dat_b_o <= adc_to_twos(adc_dat_b_i);
  end

  //--------------------------------------------------------------------
  // DAC transmit
  //--------------------------------------------------------------------

  // Channel B waits one slot while A is on the bus
  always_ff @(posedge adc_clk) begin
    if (!phase_q) begin
      dac_b_q <= twos_to_dac(dac_dat_b_i);
    end
    dac_rst_o <= dac_rst;                     // Registered reset to the pin
  end

  always_ff @(posedge adc_clk) begin
    if (dac_rst) begin
      phase_q   <= 1'b0;
      dac_dat_o <= '0;
      dac_sel_o <= 1'b0;
      dac_wrt_o <= 1'b0;
    end else begin
      phase_q   <= ~phase_q;                  // Two slots per sample pair
      dac_wrt_o <= 1'b1;                      // Write in every slot
      dac_sel_o <= ~phase_q;                  // A slot follows phase 0
      if (!phase_q) begin
        dac_dat_o <= twos_to_dac(dac_dat_a_i); // Channel A goes out next
      end else begin
        dac_dat_o <= dac_b_q;                 // Then the held channel B
      end
    end
  end

endmodule

// ==== src/analog_pkg.sv ====
//----------------------------------------------------------------------
// Analog front end shared definitions
// Sample widths, PWM constants, monitor addresses and code conversion
//----------------------------------------------------------------------

package analog_pkg;

  //--------------------------------------------------------------------
  // Fast converters
  //--------------------------------------------------------------------

  localparam int FAST_W = 14;                     // Fast ADC and DAC sample width

  typedef logic signed [FAST_W-1:0] adc_sample_t; // Two's complement sample
  typedef logic        [FAST_W-1:0] dac_code_t;   // Raw DAC pin code

  //--------------------------------------------------------------------
  // Slow PWM DAC
  //--------------------------------------------------------------------

  typedef logic [7:0] pwm_cnt_t;                  // Period count and duty

  localparam pwm_cnt_t PWM_FULL  = 8'd156;        // Last count, 100 % duty
  localparam int       PWM_BLOCK = 16;            // Periods per dither block
  localparam int       PWM_CH    = 4;             // Number of PWM outputs

  // One input word, seen whole or as duty and dither fields
  typedef union packed {
    logic [23:0] raw;                             // Word as written by software
    struct packed {
      pwm_cnt_t    duty;                          // Base duty, upper byte
      logic [15:0] dither;                        // One extra count per set bit
    } f;
  } pwm_word_u;

  //--------------------------------------------------------------------
  // Monitor ADC readout
  //--------------------------------------------------------------------

  localparam int MON_W = 12;                      // Monitor result width
  localparam int DRP_W = 16;                      // Readout word width

  typedef logic [MON_W-1:0] mon_code_t;           // Left-justified result
  typedef logic [4:0]       mon_addr_t;           // Monitor channel address

  localparam mon_addr_t MON_TEMP  = 5'd0;         // Die temperature
  localparam mon_addr_t MON_INT   = 5'd1;         // VCCINT
  localparam mon_addr_t MON_AUX   = 5'd2;         // VCCAUX
  localparam mon_addr_t MON_VIN   = 5'd3;         // Dedicated VP/VN input
  localparam mon_addr_t MON_BRAM  = 5'd6;         // VCCBRAM
  localparam mon_addr_t MON_PINT  = 5'd13;        // VCCPINT
  localparam mon_addr_t MON_PAUX  = 5'd14;        // VCCPAUX
  localparam mon_addr_t MON_DDR   = 5'd15;        // VCCO DDR
  localparam mon_addr_t MON_SLX_B = 5'd16;        // Aux 0, slow input B
  localparam mon_addr_t MON_SLX_C = 5'd17;        // Aux 1, slow input C
  localparam mon_addr_t MON_SLX_A = 5'd24;        // Aux 8, slow input A
  localparam mon_addr_t MON_SLX_D = 5'd25;        // Aux 9, slow input D

  //--------------------------------------------------------------------
  // Code conversion
  //--------------------------------------------------------------------

  // Offset binary with negative slope into two's complement
  function automatic adc_sample_t adc_to_twos(input logic [FAST_W-1:0] code);
    return {code[FAST_W-1], ~code[FAST_W-2:0]};  // Keep MSB, flip the rest
  endfunction

  // Two's complement into inverted offset binary for the DAC
  function automatic dac_code_t twos_to_dac(input adc_sample_t smp);
    return {smp[FAST_W-1], ~smp[FAST_W-2:0]};    // Same rule, other direction
  endfunction

endpackage
